// ==== filelist.f ====
+incdir+hdl
hdl/geom_pkg.sv
hdl/pixel_pkg.sv
hdl/line_rasterizer.sv
hdl/pixel_fifo.sv
hdl/framebuffer_writer.sv
hdl/line_draw_top.sv
bench/line_draw_properties.sv
bench/line_draw_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := line_draw_tb
FILELIST  := filelist.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Everything OK
VFLAGS    := --binary --timing --assert -j 0 --Mdir $(BUILD_DIR) --top-module $(TOP)
LINTFLAGS := --lint-only --timing --assert --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
	  echo "Simulation passed"; \
	else \
	  echo "Simulation did not pass"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/line_draw_tb.sv ====
// Testbench for the line drawing engine
// Bresenham reference model, line commands, framebuffer readback compare

`timescale 1ns/10ps
`default_nettype none

module line_draw_tb
  import geom_pkg::*, pixel_pkg::*;
();

  localparam int SIDE       = 1 << $bits(coord_t);
  localparam int CELLS      = SIDE * SIDE;
  localparam int WAIT_LIMIT = 2000;  // Cycles

  logic   clk;
  logic   arst_n;
  logic   plot;
  coord_t x0, y0, x1, y1;
  color_t color;
  logic   busy;
  logic   rd_en;
  coord_t rd_x;
  coord_t rd_y;
  color_t rd_data;
  logic   idle;

  color_t model_fb [CELLS];
  bit     marked [CELLS];  // Pixels the model has written
  int     errors;
  bit     timed_out;

  // End points around the centre, four shallow then four steep
  int end_x [8] = '{50, 14, 14, 50, 40, 24, 24, 40};
  int end_y [8] = '{40, 40, 24, 24, 55, 55, 9, 9};

  line_draw_top line_draw_top_i (
    .clk     (clk),
    .arst_n  (arst_n),
    .plot    (plot),
    .x0      (x0),
    .y0      (y0),
    .x1      (x1),
    .y1      (y1),
    .color   (color),
    .busy    (busy),
    .rd_en   (rd_en),
    .rd_x    (rd_x),
    .rd_y    (rd_y),
    .rd_data (rd_data),
    .idle    (idle)
  );

  bind line_draw_top line_draw_properties line_draw_properties_i (
    .clk           (clk),
    .arst_n        (arst_n),
    .plot          (plot),
    .busy          (busy),
    .pix_valid     (pix_valid),
    .credit_return (credit_return),
    .out_valid     (out_valid),
    .out_ready     (out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Plots one line into the model, returns its pixel count
  function automatic int bresenham_model(input int ax, input int ay, input int bx,
                                         input int by, input color_t c);
    int p0x, p0y, p1x, p1y;
    int dx, dy, err, ystep, y, addr, n;
    bit steep;
    {p0x, p0y, p1x, p1y} = {ax, ay, bx, by};
    dx    = (bx > ax) ? bx - ax : ax - bx;
    dy    = (by > ay) ? by - ay : ay - by;
    steep = dy > dx;
    if (steep) begin
      {p0x, p0y} = {p0y, p0x};
      {p1x, p1y} = {p1y, p1x};
    end
    if (p0x > p1x) begin
      {p0x, p1x} = {p1x, p0x};
      {p0y, p1y} = {p1y, p0y};
    end
    dx    = p1x - p0x;
    dy    = (p1y > p0y) ? p1y - p0y : p0y - p1y;
    err   = dx / 2;
    ystep = (p0y < p1y) ? 1 : -1;
    y     = p0y;
    n     = 0;
    for (int x = p0x; x <= p1x; x++) begin
      addr = steep ? x * SIDE + y : y * SIDE + x;  // Row major, y selects the row
      model_fb[addr] = c;
      marked[addr]   = 1'b1;
      n++;
      err -= dy;
      if (err < 0) begin
        y   += ystep;
        err += dx;
      end
    end
    return n;
  endfunction

  task automatic report_timeout(input string what);
    errors++;
    timed_out = 1'b1;
    $display("Timeout while waiting for %s", what);
  endtask

  // One command, optionally with random reads that stall the writer
  task automatic draw_line(input int ax, input int ay, input int bx, input int by,
                           input color_t c, input bit stall);
    int expected;
    int produced;
    int t;
    if (timed_out) return;
    t = 0;
    while (busy && !timed_out) begin
      if (t == WAIT_LIMIT) report_timeout("the rasterizer to take a command");
      t++;
      @(negedge clk);
    end
    if (timed_out) return;
    expected = bresenham_model(ax, ay, bx, by, c);
    plot  = 1'b1;
    x0    = coord_t'(ax);
    y0    = coord_t'(ay);
    x1    = coord_t'(bx);
    y1    = coord_t'(by);
    color = c;
    @(negedge clk);
    plot = 1'b0;
    assert (busy) else begin
      errors++;
      $display("Line command was not accepted, busy stayed low");
    end
    produced = 0;
    t = 0;
    while (busy && !timed_out) begin
      if (line_draw_top_i.pix_valid) produced++;
      if (stall) begin
        rd_en = ($urandom_range(3) != 0);  // Drains about one cycle in four
        rd_x  = coord_t'($urandom);
        rd_y  = coord_t'($urandom);
      end
      if (t == WAIT_LIMIT) report_timeout("busy to fall at the end of a line");
      t++;
      @(negedge clk);
    end
    rd_en = 1'b0;
    assert (produced == expected) else begin
      errors++;
      $display("ERROR pix_valid count: got %h, expected %h", produced, expected);
    end
  endtask

  // Reads back every pixel the model has marked
  task automatic compare_framebuffer();
    int t;
    int a;
    if (timed_out) return;
    t = 0;
    while (!idle && !timed_out) begin
      if (t == WAIT_LIMIT) report_timeout("idle before readback");
      t++;
      @(negedge clk);
    end
    for (a = 0; a < CELLS && !timed_out; a++) begin
      if (marked[a]) begin
        rd_en = 1'b1;
        rd_x  = coord_t'(a % SIDE);
        rd_y  = coord_t'(a / SIDE);
        @(negedge clk);  // Registered read data
        assert (rd_data == model_fb[a]) else begin
          errors++;
          $display("ERROR rd_data at x %h y %h: got %h, expected %h",
                   rd_x, rd_y, rd_data, model_fb[a]);
        end
      end
    end
    rd_en = 1'b0;
  endtask

  initial begin
    int i;
    void'($urandom(32'h8bb7cc69));
    errors    = 0;
    timed_out = 1'b0;
    arst_n    = 1'b0;
    plot      = 1'b0;
    {x0, y0, x1, y1} = '0;
    color     = '0;
    rd_en     = 1'b0;
    rd_x      = '0;
    rd_y      = '0;
    repeat (5) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);
    assert (idle && !busy) else begin
      errors++;
      $display("Engine is not idle after reset");
    end

    draw_line(10, 20, 10, 20, 8'ha5, 1'b0);  // Single point
    compare_framebuffer();

    for (i = 0; i < 8; i++) begin
      draw_line(32, 32, end_x[i], end_y[i], color_t'(8'h30 + i), 1'b0);
    end
    compare_framebuffer();

    // Readback competes with the writer
    for (i = 0; i < 6; i++) begin
      draw_line($urandom_range(SIDE - 1), $urandom_range(SIDE - 1), $urandom_range(SIDE - 1),
                $urandom_range(SIDE - 1), color_t'($urandom), 1'b1);
    end
    compare_framebuffer();

    for (i = 0; i < 40; i++) begin
      draw_line($urandom_range(SIDE - 1), $urandom_range(SIDE - 1), $urandom_range(SIDE - 1),
                $urandom_range(SIDE - 1), color_t'($urandom), 1'b0);
    end
    compare_framebuffer();

    $display("Line draw test finished with %0d errors", errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/line_draw_properties.sv ====
// Concurrent checks on the pixel credit link and the command port
// Bound into the line drawing top level

`timescale 1ns/10ps
`default_nettype none

`include "line_settings.svh"

module line_draw_properties (
  input logic clk,
  input logic arst_n,
  input logic plot,
  input logic busy,
  input logic pix_valid,
  input logic credit_return,
  input logic out_valid,
  input logic out_ready
);

  int credits;  // Shadow of the rasterizer credit counter
  int fill;     // Pixels held in the FIFO

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      credits <= `FIFO_DEPTH;
      fill    <= 0;
    end else begin
      credits <= credits + int'(credit_return) - int'(pix_valid);
      fill    <= fill + int'(pix_valid) - int'(out_valid && out_ready);
    end
  end

  no_pixel_without_credit: assert property (
    @(posedge clk) disable iff (!arst_n) pix_valid |-> credits > 0
  ) else $error("pix_valid high with no credit left");

  fifo_within_depth: assert property (
    @(posedge clk) disable iff (!arst_n) fill <= `FIFO_DEPTH
  ) else $error("pixel FIFO holds more entries than its depth");

  // Only an accepted plot may raise busy
  busy_needs_plot: assert property (
    @(posedge clk) disable iff (!arst_n) (!busy && !plot) |=> !busy
  ) else $error("busy rose without a plot command");

endmodule

`default_nettype wire

// ==== hdl/line_draw_top.sv ====
// Line drawing engine top level
// Rasterizer, pixel FIFO and framebuffer writer, plus idle flag

`timescale 1ns/10ps
`default_nettype none

module line_draw_top
  import geom_pkg::*, pixel_pkg::*;
(
  input  logic   clk,
  input  logic   arst_n,
  input  logic   plot,
  input  coord_t x0,
  input  coord_t y0,
  input  coord_t x1,
  input  coord_t y1,
  input  color_t color,
  output logic   busy,
  input  logic   rd_en,
  input  coord_t rd_x,
  input  coord_t rd_y,
  output color_t rd_data,
  output logic   idle
);

  logic   pix_valid;
  pixel_t pix_data;
  logic   credit_return;
  logic   out_valid;
  pixel_t out_data;
  logic   out_ready;
  logic   fifo_empty;

  line_rasterizer line_rasterizer_i (
    .clk           (clk),
    .arst_n        (arst_n),
    .plot          (plot),
    .x0            (x0),
    .y0            (y0),
    .x1            (x1),
    .y1            (y1),
    .color         (color),
    .credit_return (credit_return),
    .busy          (busy),
    .pix_valid     (pix_valid),
    .pix_data      (pix_data)
  );

  pixel_fifo pixel_fifo_i (
    .clk           (clk),
    .arst_n        (arst_n),
    .pix_valid     (pix_valid),
    .pix_data      (pix_data),
    .out_ready     (out_ready),
    .credit_return (credit_return),
    .out_valid     (out_valid),
    .out_data      (out_data),
    .empty         (fifo_empty)
  );

  framebuffer_writer framebuffer_writer_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .out_valid (out_valid),
    .out_data  (out_data),
    .rd_en     (rd_en),
    .rd_x      (rd_x),
    .rd_y      (rd_y),
    .out_ready (out_ready),
    .rd_data   (rd_data)
  );

  // Writes land on the drain edge, so an empty FIFO means nothing pending
  assign idle = !busy && fifo_empty;

endmodule

`default_nettype wire

// ==== hdl/framebuffer_writer.sv ====
// Framebuffer writer
// 64 by 64 color memory, pixel write side and registered readback

`timescale 1ns/10ps
`default_nettype none

module framebuffer_writer
  import geom_pkg::*, pixel_pkg::*;
(
  input  logic   clk,
  input  logic   arst_n,
  input  logic   out_valid,
  input  pixel_t out_data,
  input  logic   rd_en,
  input  coord_t rd_x,
  input  coord_t rd_y,
  output logic   out_ready,
  output color_t rd_data
);

  localparam int ADDR_W = 2 * $bits(coord_t);

  color_t            fb_mem [1 << ADDR_W];
  logic [ADDR_W-1:0] wr_addr;
  logic [ADDR_W-1:0] rd_addr;
  logic              wr_en;

  // Readback owns the memory port, pixels wait
  assign out_ready = !rd_en;
  assign wr_en     = out_valid && out_ready;

  // Row major, y selects the row
  assign wr_addr = {out_data.pos.y, out_data.pos.x};
  assign rd_addr = {rd_y, rd_x};

  always_ff @(posedge clk) begin
    if (wr_en) fb_mem[wr_addr] <= out_data.col;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_data <= '0;
    end else if (rd_en) begin
      rd_data <= fb_mem[rd_addr];  // Valid the cycle after rd_en
    end
  end

endmodule

`default_nettype wire

// ==== hdl/pixel_fifo.sv ====
// Credit based pixel FIFO
// Circular buffer, one credit returned per drained pixel

`timescale 1ns/10ps
`default_nettype none

`include "line_settings.svh"

module pixel_fifo
  import pixel_pkg::*;
(
  input  logic   clk,
  input  logic   arst_n,
  input  logic   pix_valid,
  input  pixel_t pix_data,
  input  logic   out_ready,
  output logic   credit_return,
  output logic   out_valid,
  output pixel_t out_data,
  output logic   empty
);

  localparam int DEPTH = `FIFO_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  pixel_t             mem [DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [CNT_W-1:0]   count;
  logic               push;
  logic               pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // Sender holds credits, so a push always finds room
  assign push = pix_valid;
  assign pop  = out_valid && out_ready;

  assign empty         = (count == '0);
  assign out_valid     = !empty;
  assign out_data      = mem[rd_ptr];
  assign credit_return = pop;  // Slot freed this cycle

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= ptr_inc(wr_ptr);
      if (pop)  rd_ptr <= ptr_inc(rd_ptr);
      count <= count + CNT_W'(push) - CNT_W'(pop);
    end
  end

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= pix_data;
  end

endmodule

`default_nettype wire

// ==== hdl/line_rasterizer.sv ====
// Bresenham line rasterizer
// Setup of one line command, pixel stream under a credit counter

`timescale 1ns/10ps
`default_nettype none

`include "line_settings.svh"

module line_rasterizer
  import geom_pkg::*, pixel_pkg::*;
(
  input  logic   clk,
  input  logic   arst_n,
  input  logic   plot,          // Command strobe
  input  coord_t x0,
  input  coord_t y0,
  input  coord_t x1,
  input  coord_t y1,
  input  color_t color,
  input  logic   credit_return, // One credit back per drained pixel
  output logic   busy,
  output logic   pix_valid,
  output pixel_t pix_data
);

  localparam int CRED_W = $clog2(`FIFO_DEPTH + 1);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_AXES,   // Steep test and axis swap
    ST_ORDER,  // Left to right ordering
    ST_PREP,   // Y step direction
    ST_DRAW
  } state_t;

  state_t             state;
  logic [CRED_W-1:0]  credits;
  logic               steep;
  logic               ystep;   // 1 counts y up
  point_t             cur;     // Walking point, axes swapped when steep
  point_t             fin;
  coord_t             dx;
  coord_t             dy;
  coord_t             err;
  color_t             cmd_color;
  point_t             out_pt;
  logic               accept;
  logic               last_pix;

  assign busy     = (state != ST_IDLE);
  assign accept   = plot && !busy;
  assign last_pix = (cur.x == fin.x);

  // A pixel goes out on every draw cycle that has a credit
  assign pix_valid = (state == ST_DRAW) && (credits != '0);

  // Undo the axis swap on the way out
  assign out_pt   = steep ? {cur.y, cur.x} : cur;
  assign pix_data = '{pos: out_pt, col: cmd_color};

  // Credits never exceed the FIFO depth, a return follows each drain
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      credits <= CRED_W'(`FIFO_DEPTH);
    end else begin
      credits <= credits + CRED_W'(credit_return) - CRED_W'(pix_valid);
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= ST_IDLE;
      steep <= 1'b0;
      ystep <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (accept) state <= ST_AXES;
        end
        ST_AXES: begin
          steep <= (dy > dx);
          state <= ST_ORDER;
        end
        ST_ORDER: begin
          state <= ST_PREP;
        end
        ST_PREP: begin
          ystep <= (cur.y < fin.y);
          state <= ST_DRAW;
        end
        ST_DRAW: begin
          if (pix_valid && last_pix) state <= ST_IDLE; // End pixel sent
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Line geometry, only meaningful while busy
  always_ff @(posedge clk) begin
    case (state)
      ST_IDLE: begin
        if (accept) begin
          cur       <= '{x: x0, y: y0};
          fin       <= '{x: x1, y: y1};
          cmd_color <= color;
          dx        <= (x1 > x0) ? x1 - x0 : x0 - x1;
          dy        <= (y1 > y0) ? y1 - y0 : y0 - y1;
        end
      end
      ST_AXES: begin
        if (dy > dx) begin
          // Walk along y instead
          cur <= {cur.y, cur.x};
          fin <= {fin.y, fin.x};
          dx  <= dy;
          dy  <= dx;
        end
      end
      ST_ORDER: begin
        if (cur.x > fin.x) begin
          cur <= fin;
          fin <= cur;
        end
        err <= dx >> 1;
      end
      ST_DRAW: begin
        if (pix_valid && !last_pix) begin
          if (err < dy) begin
            cur.y <= ystep ? cur.y + 1'b1 : cur.y - 1'b1;
            err   <= err - dy + dx;  // Stays within 0 .. dx-1
          end else begin
            err   <= err - dy;
          end
          cur.x <= cur.x + 1'b1;
        end
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/pixel_pkg.sv ====
// Pixel types for the line engine
// Color word and the pixel record sent down the pipe

`default_nettype none

`include "line_settings.svh"

package pixel_pkg;

  import geom_pkg::*;

  // Framebuffer color
  typedef logic [`COLOR_W-1:0] color_t;

  // One plotted pixel, position then color
  typedef struct packed {
    point_t pos;
    color_t col;
  } pixel_t;

endpackage

`default_nettype wire

// ==== hdl/geom_pkg.sv ====
// Geometry types for the line engine
// Single coordinate and x/y point

`default_nettype none

`include "line_settings.svh"

package geom_pkg;

  // One unsigned screen coordinate
  typedef logic [`COORD_W-1:0] coord_t;

  // Screen position, x in the upper half
  typedef struct packed {
    coord_t x;
    coord_t y;
  } point_t;

endpackage

`default_nettype wire

// ==== hdl/line_settings.svh ====
// Global sizes for the line drawing engine
// Coordinate and color widths, pixel FIFO depth

`ifndef LINE_SETTINGS_SVH
`define LINE_SETTINGS_SVH

// Bits per coordinate, 64 by 64 framebuffer
`define COORD_W 6

// Bits per stored color
`define COLOR_W 8

// Pixel FIFO entries, also the rasterizer start credit
`define FIFO_DEPTH 4

`endif
